/* lcd_pkg.sv */
package lcd_pkg;

	// ----------------------------------------
	// Bus and timing types
	// ----------------------------------------
	typedef logic [7:0]  lcd_byte_t;	// One byte on DB[7:0]
	typedef logic [19:0] lcd_delay_t;	// Wait length in CLK cycles

	typedef enum logic {
		KIND_INSTR = 1'b0,	// RS low
		KIND_DATA  = 1'b1	// RS high
	} lcd_kind_t;

	typedef enum logic [2:0] {
		WAIT_DATA,	// ~250 ns after a character
		WAIT_SHORT,	// 42 us, most instructions
		WAIT_LONG,	// 1.64 ms, clear
		WAIT_INIT1,	// 4.1 ms after first function set
		WAIT_INIT2	// 100 us after later function sets
	} lcd_wait_t;

	// ----------------------------------------
	// Instruction bytes
	// ----------------------------------------
	localparam lcd_byte_t CMD_FUNCTION_SET = 8'b0011_1000;	// 8-bit, 2 lines, 5x7
	localparam lcd_byte_t CMD_DISPLAY_OFF  = 8'b0000_1000;	// Display, cursor, blink off
	localparam lcd_byte_t CMD_CLEAR        = 8'b0000_0001;	// Clear DDRAM, cursor home
	localparam lcd_byte_t CMD_ENTRY_NORMAL = 8'b0000_0110;	// Increment, no shift
	localparam lcd_byte_t CMD_DISPLAY_ON   = 8'b0000_1100;	// Display on, cursor off

	// ----------------------------------------
	// Default counts at 24 MHz (41.67 ns)
	// ----------------------------------------
	localparam lcd_delay_t DEF_E_HIGH  = 20'd6;		// 250 ns
	localparam lcd_delay_t DEF_DATA    = 20'd6;		// 250 ns
	localparam lcd_delay_t DEF_SHORT   = 20'd1008;		// 42 us
	localparam lcd_delay_t DEF_LONG    = 20'd39360;	// 1.64 ms
	localparam lcd_delay_t DEF_INIT1   = 20'd98400;	// 4.1 ms
	localparam lcd_delay_t DEF_INIT2   = 20'd2400;		// 100 us
	localparam lcd_delay_t DEF_POWERUP = 20'd360000;	// 15 ms after VDD

endpackage

/* lcd_delay_timer.sv */
module lcd_delay_timer import lcd_pkg::*; (
	input  logic       CLK,
	input  logic       RST,
	input  logic       load,	// Start a new wait, restarts a running one
	input  lcd_delay_t count,	// Wait length, at least 1
	output logic       expired	// One cycle, count cycles after load
);

	lcd_delay_t cnt;	// Cycles left including the current one
	logic       running;

	always_ff @(posedge CLK) begin
		if (RST) begin
			cnt     <= '0;
			running <= 1'b0;
		end else if (load) begin
			cnt     <= count;
			running <= 1'b1;
		end else if (running) begin
			cnt <= cnt - lcd_delay_t'(1);
			if (cnt == lcd_delay_t'(1)) begin
				running <= 1'b0;	// Last cycle of the wait
			end
		end
	end

	// Fires in the cycle the counter reaches its final count
	assign expired = running && (cnt == lcd_delay_t'(1));

endmodule

/* lcd_init_steps.sv */
module lcd_init_steps import lcd_pkg::*; (
	input  logic      CLK,
	input  logic      RST,
	input  logic      step,	// Current command finished
	output lcd_byte_t cmd,
	output lcd_wait_t cmd_wait,
	output logic      last	// Final clear of the sequence
);

	localparam int unsigned N_STEPS = 9;

	logic [3:0] idx;	// Table position

	always_ff @(posedge CLK) begin
		if (RST) begin
			idx <= '0;
		end else if (step) begin
			idx <= last ? 4'd0 : idx + 4'd1;	// Wrap so a rerun starts clean
		end
	end

	// ----------------------------------------
	// Command table
	// ----------------------------------------
	always_comb begin
		case (idx)
			4'd0: begin	// First function set after power-up
				cmd      = CMD_FUNCTION_SET;
				cmd_wait = WAIT_INIT1;
			end
			4'd1, 4'd2, 4'd3: begin	// Repeated function sets
				cmd      = CMD_FUNCTION_SET;
				cmd_wait = WAIT_INIT2;
			end
			4'd4: begin
				cmd      = CMD_DISPLAY_OFF;
				cmd_wait = WAIT_SHORT;
			end
			4'd5, 4'd8: begin	// Clear needs the long wait
				cmd      = CMD_CLEAR;
				cmd_wait = WAIT_LONG;
			end
			4'd6: begin
				cmd      = CMD_ENTRY_NORMAL;
				cmd_wait = WAIT_SHORT;
			end
			default: begin	// Step 7
				cmd      = CMD_DISPLAY_ON;
				cmd_wait = WAIT_SHORT;
			end
		endcase
	end

	assign last = (idx == 4'(N_STEPS - 1));

endmodule

/* lcd_bus_cycle.sv */
module lcd_bus_cycle import lcd_pkg::*; #(
	parameter lcd_delay_t E_HIGH  = DEF_E_HIGH,
	parameter lcd_delay_t T_DATA  = DEF_DATA,
	parameter lcd_delay_t T_SHORT = DEF_SHORT,
	parameter lcd_delay_t T_LONG  = DEF_LONG,
	parameter lcd_delay_t T_INIT1 = DEF_INIT1,
	parameter lcd_delay_t T_INIT2 = DEF_INIT2
) (
	input  logic      CLK,
	input  logic      RST,
	input  logic      start,	// Accepted only while idle
	input  logic      rs,
	input  lcd_byte_t tx_byte,	// Byte for DB[7:0]
	input  lcd_wait_t wait_class,
	output logic      done,	// Execution wait over
	output logic      lcd_rs,
	output logic      lcd_e,
	output lcd_byte_t lcd_db
);

	typedef enum logic [1:0] {
		PH_IDLE,
		PH_SETUP,	// RS/DB settle with E low
		PH_STROBE,	// E high
		PH_EXEC	// LCD busy with the byte
	} phase_t;

	phase_t     phase;
	lcd_delay_t e_cnt;	// E high cycles left
	lcd_wait_t  wait_q;	// Class of the byte in flight
	lcd_delay_t wait_len;
	logic       exec_load;	// High in the cycle E is low again
	logic       exec_expired;

	// Wait class to cycle count
	always_comb begin
		case (wait_q)
			WAIT_DATA:  wait_len = T_DATA;
			WAIT_LONG:  wait_len = T_LONG;
			WAIT_INIT1: wait_len = T_INIT1;
			WAIT_INIT2: wait_len = T_INIT2;
			default:    wait_len = T_SHORT;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (phase == PH_IDLE && start) begin
			wait_q <= wait_class;
		end
	end

	// ----------------------------------------
	// Bus phases
	// ----------------------------------------
	always_ff @(posedge CLK) begin
		if (RST) begin
			phase     <= PH_IDLE;
			lcd_rs    <= 1'b0;
			lcd_e     <= 1'b0;
			lcd_db    <= '0;
			e_cnt     <= '0;
			exec_load <= 1'b0;
		end else begin
			exec_load <= 1'b0;
			case (phase)
				PH_IDLE: begin
					if (start) begin
						lcd_rs <= rs;	// RS and DB change only here
						lcd_db <= tx_byte;
						phase  <= PH_SETUP;
					end
				end
				PH_SETUP: begin	// One setup cycle is over
					lcd_e <= 1'b1;
					e_cnt <= E_HIGH;
					phase <= PH_STROBE;
				end
				PH_STROBE: begin
					if (e_cnt == lcd_delay_t'(1)) begin
						lcd_e     <= 1'b0;	// Falling edge latches the byte
						exec_load <= 1'b1;
						phase     <= PH_EXEC;
					end else begin
						e_cnt <= e_cnt - lcd_delay_t'(1);
					end
				end
				default: begin	// PH_EXEC
					if (exec_expired) begin
						phase <= PH_IDLE;
					end
				end
			endcase
		end
	end

	lcd_delay_timer i_exec_timer (
		.CLK     (CLK),
		.RST     (RST),
		.load    (exec_load),
		.count   (wait_len),
		.expired (exec_expired)
	);

	assign done = exec_expired;	// Timer only runs in PH_EXEC

endmodule

/* lcd_host_port.sv */
module lcd_host_port import lcd_pkg::*; (
	input  logic      CLK,
	input  logic      RST,
	input  logic      req_valid,	// Spends the host's credit
	input  lcd_kind_t req_kind,
	input  lcd_byte_t req_byte,
	input  logic      take,	// Sequencer accepted the request
	input  logic      release_credit,	// Controller free again
	output logic      pending,
	output lcd_kind_t pend_kind,
	output lcd_byte_t pend_byte,
	output logic      credit	// One-cycle credit to the host
);

	// ----------------------------------------
	// Request holding register
	// ----------------------------------------
	always_ff @(posedge CLK) begin
		if (req_valid) begin
			pend_kind <= req_kind;	// Held until the next request
			pend_byte <= req_byte;
		end
	end

	always_ff @(posedge CLK) begin
		if (RST) begin
			pending <= 1'b0;
		end else if (req_valid) begin
			pending <= 1'b1;	// Only one credit out, so never overwritten
		end else if (take) begin
			pending <= 1'b0;
		end
	end

	// ----------------------------------------
	// Credit return
	// ----------------------------------------
	always_ff @(posedge CLK) begin
		if (RST) begin
			credit <= 1'b0;	// Host starts with no credit
		end else begin
			credit <= release_credit;	// One release, one credit
		end
	end

endmodule

/* lcd_sequencer.sv */
module lcd_sequencer import lcd_pkg::*; #(
	parameter lcd_delay_t T_POWERUP = DEF_POWERUP
) (
	input  logic      CLK,
	input  logic      RST,
	input  logic      pending,
	input  lcd_kind_t pend_kind,
	input  lcd_byte_t pend_byte,
	output logic      take,
	output logic      release_credit,
	input  lcd_byte_t init_cmd,
	input  lcd_wait_t init_wait,
	input  logic      init_last,
	output logic      init_step,
	output logic      bus_start,
	output logic      bus_rs,
	output lcd_byte_t bus_byte,
	output lcd_wait_t bus_wait,
	input  logic      bus_done
);

	typedef enum logic [2:0] {
		S_PU_LOAD,	// Arm the power-up timer
		S_PU_WAIT,	// VDD settling
		S_INIT_ISSUE,
		S_INIT_WAIT,
		S_IDLE,	// Host owns the credit
		S_HOST_ISSUE,
		S_HOST_WAIT
	} state_t;

	state_t state;
	logic   pu_expired;

	lcd_delay_timer i_pu_timer (
		.CLK     (CLK),
		.RST     (RST),
		.load    (state == S_PU_LOAD),
		.count   (T_POWERUP),
		.expired (pu_expired)
	);

	// ----------------------------------------
	// State register
	// ----------------------------------------
	always_ff @(posedge CLK) begin
		if (RST) begin
			state <= S_PU_LOAD;	// Any reset restarts power-up
		end else begin
			case (state)
				S_PU_LOAD:    state <= S_PU_WAIT;
				S_PU_WAIT:    if (pu_expired) state <= S_INIT_ISSUE;
				S_INIT_ISSUE: state <= S_INIT_WAIT;
				S_INIT_WAIT:  if (bus_done) state <= init_last ? S_IDLE : S_INIT_ISSUE;
				S_IDLE:       if (pending) state <= S_HOST_ISSUE;
				S_HOST_ISSUE: state <= S_HOST_WAIT;
				default:      if (bus_done) state <= S_IDLE;	// S_HOST_WAIT
			endcase
		end
	end

	// ----------------------------------------
	// Outputs
	// ----------------------------------------
	always_comb begin
		take           = (state == S_IDLE) && pending;
		init_step      = (state == S_INIT_WAIT) && bus_done;
		release_credit = ((state == S_INIT_WAIT) && bus_done && init_last)
			|| ((state == S_HOST_WAIT) && bus_done);	// End of init or transfer
		bus_start      = (state == S_INIT_ISSUE) || (state == S_HOST_ISSUE);
		if (state == S_HOST_ISSUE) begin	// Holding register is stable here
			bus_rs   = (pend_kind == KIND_DATA);
			bus_byte = pend_byte;
			bus_wait = (pend_kind == KIND_DATA) ? WAIT_DATA : WAIT_SHORT;
		end else begin	// Init steps are always instructions
			bus_rs   = 1'b0;
			bus_byte = init_cmd;
			bus_wait = init_wait;
		end
	end

endmodule

/* lcd_top.sv */
module lcd_top import lcd_pkg::*; #(
	parameter lcd_delay_t E_HIGH    = DEF_E_HIGH,
	parameter lcd_delay_t T_DATA    = DEF_DATA,
	parameter lcd_delay_t T_SHORT   = DEF_SHORT,
	parameter lcd_delay_t T_LONG    = DEF_LONG,
	parameter lcd_delay_t T_INIT1   = DEF_INIT1,
	parameter lcd_delay_t T_INIT2   = DEF_INIT2,
	parameter lcd_delay_t T_POWERUP = DEF_POWERUP
) (
	input  logic      CLK,
	input  logic      RST,
	input  logic      req_valid,
	input  lcd_kind_t req_kind,
	input  lcd_byte_t req_byte,
	output logic      credit,
	output logic      lcd_rs,
	output logic      lcd_e,
	output lcd_byte_t lcd_db	// R/W is tied low on the board
);

	logic      pending;
	lcd_kind_t pend_kind;
	lcd_byte_t pend_byte;
	logic      take;
	logic      release_credit;
	lcd_byte_t init_cmd;
	lcd_wait_t init_wait;
	logic      init_last;
	logic      init_step;
	logic      bus_start;
	logic      bus_rs;
	lcd_byte_t bus_byte;
	lcd_wait_t bus_wait;
	logic      bus_done;

	lcd_host_port i_host_port (
		.CLK (CLK), .RST (RST),
		.req_valid (req_valid), .req_kind (req_kind), .req_byte (req_byte),
		.take (take), .release_credit (release_credit),
		.pending (pending), .pend_kind (pend_kind), .pend_byte (pend_byte),
		.credit (credit)
	);

	lcd_sequencer #(.T_POWERUP (T_POWERUP)) i_sequencer (
		.CLK (CLK), .RST (RST),
		.pending (pending), .pend_kind (pend_kind), .pend_byte (pend_byte),
		.take (take), .release_credit (release_credit),
		.init_cmd (init_cmd), .init_wait (init_wait), .init_last (init_last),
		.init_step (init_step),
		.bus_start (bus_start), .bus_rs (bus_rs), .bus_byte (bus_byte),
		.bus_wait (bus_wait), .bus_done (bus_done)
	);

	lcd_init_steps i_init_steps (
		.CLK (CLK), .RST (RST), .step (init_step),
		.cmd (init_cmd), .cmd_wait (init_wait), .last (init_last)
	);

	lcd_bus_cycle #(
		.E_HIGH (E_HIGH), .T_DATA (T_DATA), .T_SHORT (T_SHORT),
		.T_LONG (T_LONG), .T_INIT1 (T_INIT1), .T_INIT2 (T_INIT2)
	) i_bus_cycle (
		.CLK (CLK), .RST (RST),
		.start (bus_start), .rs (bus_rs), .tx_byte (bus_byte), .wait_class (bus_wait),
		.done (bus_done), .lcd_rs (lcd_rs), .lcd_e (lcd_e), .lcd_db (lcd_db)
	);

endmodule

/* tb_lcd_top.sv */
module tb_lcd_top import lcd_pkg::*; ;
	timeunit 1ns;
	timeprecision 100ps;

	localparam lcd_delay_t E_HIGH = 3, T_DATA = 4, T_SHORT = 8, T_LONG = 20;
	localparam lcd_delay_t T_INIT1 = 30, T_INIT2 = 10, T_POWERUP = 40;
	localparam int INIT_LIMIT = 1000;	// Cycles allowed for power-up plus init

	logic CLK, RST, req_valid, credit, lcd_rs, lcd_e;
	lcd_kind_t req_kind;
	lcd_byte_t req_byte, lcd_db;

	lcd_top #(
		.E_HIGH (E_HIGH), .T_DATA (T_DATA), .T_SHORT (T_SHORT), .T_LONG (T_LONG),
		.T_INIT1 (T_INIT1), .T_INIT2 (T_INIT2), .T_POWERUP (T_POWERUP)
	) i_lcd_top (
		.CLK (CLK), .RST (RST), .req_valid (req_valid), .req_kind (req_kind),
		.req_byte (req_byte), .credit (credit), .lcd_rs (lcd_rs), .lcd_e (lcd_e),
		.lcd_db (lcd_db)
	);

	initial begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;
	end

	// ----------------------------------------
	// Bus monitor
	// ----------------------------------------
	logic        mon_rs[$];	// RS at each E fall
	lcd_byte_t   mon_db[$];
	int          mon_width[$];	// E high cycles per strobe
	int          cycle = 0, e_run = 0, fall_cycle = 0, credit_cycle = 0;
	int          credit_cnt = 0;	// Credits granted since reset
	int          spent = 0;	// Credits used by requests
	int          errors = 0, tests = 0, failed = 0;
	logic [31:0] lfsr = 32'h6509;

	always @(posedge CLK) begin
		cycle++;
		if (lcd_e) begin
			e_run++;
		end else if (e_run != 0) begin	// E just fell
			mon_rs.push_back(lcd_rs);
			mon_db.push_back(lcd_db);
			mon_width.push_back(e_run);
			fall_cycle = cycle;
			e_run = 0;
		end
		if (credit) begin
			credit_cnt++;
			credit_cycle = cycle;
		end
	end

	// ----------------------------------------
	// Helpers and compare tasks
	// ----------------------------------------
	function automatic logic [31:0] rand_bits(int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hA300_0000) : (lfsr >> 1);	// Galois step
			r = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	task automatic check_byte(lcd_byte_t got, lcd_byte_t exp, string what);
		if (got !== exp) begin
			$display("FAIL at %0t: %s got 0x%02h expected 0x%02h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic check_kind(lcd_kind_t exp, logic rs, string what);
		if (rs !== (exp == KIND_DATA)) begin
			$display("FAIL at %0t: %s RS was %b for %s", $time, what, rs, exp.name());
			errors++;
		end
	endtask

	task automatic check_count(int got, int exp, string what);
		if (got != exp) begin
			$display("FAIL at %0t: %s got %0d expected %0d", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic clear_monitor();
		mon_rs.delete();
		mon_db.delete();
		mon_width.delete();
	endtask

	task automatic do_reset();
		RST = 1'b1;
		req_valid = 1'b0;
		repeat (3) @(negedge CLK);
		RST = 1'b0;
		clear_monitor();
		credit_cnt = 0;
		spent = 0;
	endtask

	task automatic wait_credits(int target, int limit, string what);
		int n;
		n = 0;
		while (credit_cnt < target && n < limit) begin
			@(negedge CLK);
			n++;
		end
		if (credit_cnt < target) begin
			$display("Timeout: no credit came within %0d cycles during %s", limit, what);
			errors++;
		end
	endtask

	task automatic send_req(lcd_kind_t kind, lcd_byte_t b);
		if (credit_cnt <= spent) begin
			$display("Host error: request at %0t sent without a held credit", $time);
			errors++;
		end
		req_valid = 1'b1;	// Driven just after a falling edge
		req_kind = kind;
		req_byte = b;
		@(negedge CLK);
		req_valid = 1'b0;
		spent++;
	endtask

	task automatic check_init(string what);
		lcd_byte_t exp[9];
		exp = '{CMD_FUNCTION_SET, CMD_FUNCTION_SET, CMD_FUNCTION_SET, CMD_FUNCTION_SET,
			CMD_DISPLAY_OFF, CMD_CLEAR, CMD_ENTRY_NORMAL, CMD_DISPLAY_ON, CMD_CLEAR};
		check_count(mon_db.size(), 9, {what, " strobe count"});
		for (int i = 0; i < 9 && i < mon_db.size(); i++) begin
			check_kind(KIND_INSTR, mon_rs[i], $sformatf("%s step %0d", what, i));
			check_byte(mon_db[i], exp[i], $sformatf("%s step %0d", what, i));
		end
	endtask

	task automatic end_test(string name, int errs_before);
		tests++;
		if (errors > errs_before) begin
			failed++;
			$display("test %s: failed with %0d errors", name, errors - errs_before);
		end else begin
			$display("test %s: ok", name);
		end
	endtask

	// ----------------------------------------
	// Directed tests
	// ----------------------------------------
	task automatic test_init();
		int e0, high_seen;
		e0 = errors;
		high_seen = 0;
		do_reset();
		repeat (int'(T_POWERUP)) begin	// Quiet during power-up
			high_seen += int'(lcd_e | credit);
			@(negedge CLK);
		end
		check_count(high_seen, 0, "E or credit high during power-up");
		wait_credits(1, INIT_LIMIT, "initialization");
		check_init("init");
		repeat (20) @(negedge CLK);
		check_count(credit_cnt, 1, "credits after init");
		end_test("init_sequence", e0);
	endtask

	task automatic test_single(lcd_kind_t kind, string name);
		int e0;
		lcd_byte_t b;
		e0 = errors;
		b = lcd_byte_t'(rand_bits(8));
		clear_monitor();
		send_req(kind, b);
		wait_credits(spent + 1, 200, name);
		check_count(mon_db.size(), 1, {name, " strobe count"});
		if (mon_db.size() == 1) begin
			check_kind(kind, mon_rs[0], name);
			check_byte(mon_db[0], b, name);
			check_count(mon_width[0], int'(E_HIGH), {name, " E width"});
		end
		if (kind == KIND_INSTR)	// Short wait before the credit returns
			check_count(int'(credit_cycle - fall_cycle >= int'(T_SHORT)), 1, "credit gap");
		end_test(name, e0);
	endtask

	task automatic test_idle();
		int e0, base;
		e0 = errors;
		base = credit_cnt;
		repeat (200) @(negedge CLK);
		check_count(credit_cnt - base, 0, "credits while idle");
		end_test("idle_no_credit", e0);
	endtask

	task automatic test_burst();
		int e0, base;
		lcd_kind_t kinds[$];
		lcd_byte_t bytes[$];
		e0 = errors;
		base = credit_cnt;
		clear_monitor();
		for (int i = 0; i < 16; i++) begin
			wait_credits(spent + 1, 200, "burst");	// Send only on a held credit
			kinds.push_back(rand_bits(1) == 1 ? KIND_DATA : KIND_INSTR);
			bytes.push_back(lcd_byte_t'(rand_bits(8)));
			send_req(kinds[i], bytes[i]);
		end
		wait_credits(spent + 1, 200, "burst end");
		check_count(credit_cnt - base, 16, "burst credits");
		check_count(mon_db.size(), 16, "burst strobes");
		for (int i = 0; i < 16 && i < mon_db.size(); i++) begin
			check_kind(kinds[i], mon_rs[i], $sformatf("burst %0d", i));
			check_byte(mon_db[i], bytes[i], $sformatf("burst %0d", i));
		end
		end_test("random_burst", e0);
	endtask

	task automatic test_reset_mid();
		int e0, n;
		e0 = errors;
		n = 0;
		send_req(KIND_DATA, lcd_byte_t'(rand_bits(8)));
		while (!lcd_e && n < 20) begin	// Catch the strobe
			@(negedge CLK);
			n++;
		end
		if (!lcd_e) begin
			$display("Timeout: strobe never started before the mid-transfer reset");
			errors++;
		end
		RST = 1'b1;
		@(negedge CLK);
		check_count(int'(lcd_e), 0, "E after reset");
		check_count(int'(lcd_rs), 0, "RS after reset");
		check_byte(lcd_db, 8'h00, "DB after reset");
		do_reset();
		wait_credits(1, INIT_LIMIT, "re-initialization");
		check_init("reinit");
		end_test("reset_mid_transfer", e0);
	endtask

	initial begin
		RST = 1'b1;
		req_valid = 1'b0;
		req_kind = KIND_INSTR;
		req_byte = '0;
		@(negedge CLK);
		test_init();
		test_single(KIND_DATA, "data_write");
		test_single(KIND_INSTR, "instr_write");
		test_idle();
		test_burst();
		test_reset_mid();
		$display("%0d tests run, %0d failed, %0d errors", tests, failed, errors);
		if (errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

/* flist.f */
lcd_pkg.sv
lcd_delay_timer.sv
lcd_init_steps.sv
lcd_bus_cycle.sv
lcd_host_port.sv
lcd_sequencer.sv
lcd_top.sv
tb_lcd_top.sv

/* run.sh */
#!/bin/sh
# Build with Verilator, run, then decide pass or fail from the simulation log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --timescale 1ns/100ps --top-module tb_lcd_top \
	-f flist.f -o tb_lcd_top > build.log 2>&1 \
	&& ./obj_dir/tb_lcd_top > sim.log 2>&1 \
	|| { echo "Build or simulation failed, see build.log and sim.log"; exit 1; }
grep -q "All tests passed" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }
